// File: logic/duck_game_pkg.sv
package duck_game_pkg;

    // --------------------
    // widths
    // --------------------

    // screen coordinates from the mouse and for the target
    localparam int coord_w = 12;
    // random source width
    localparam int rnd_w   = 16;
    // magazine counter, holds 0..8
    localparam int count_w = 4;
    // binary score, holds 0..99
    localparam int score_w = 7;
    // one decimal digit
    localparam int digit_w = 4;
    // delay counter, large enough for the countdown
    localparam int delay_w = 6;

    // --------------------
    // game geometry
    // --------------------

    // hit box reaches this far right of target_xpos, inclusive
    localparam int duck_width   = 96;
    // hit box reaches this far below target_ypos, inclusive
    localparam int duck_height  = 32;
    // launch line, the duck always sits here
    localparam int lowest_point = 668;

    // --------------------
    // timing and limits
    // --------------------

    localparam int countdown_cycles = 40;
    localparam int death_cycles     = 20;
    // any shot that is not a hit
    localparam int reload_cycles    = 1;
    localparam int magazine_size    = 8;
    // two decimal digits on the display
    localparam int score_max        = 99;

    // game FSM
    typedef enum logic [1:0] {
        wait_for_start = 2'd0,
        delay          = 2'd1,
        hunting        = 2'd2,
        resolve        = 2'd3
    } game_state_e;

endpackage

// File: logic/shot_if.sv
`timescale 1ns/1ps

interface shot_if;
    import duck_game_pkg::*;

    // one-cycle pulse per left button press
    logic               fire;
    // one-cycle pulse per right button press
    logic               reload;
    // mouse position at the moment of the last shot
    logic [coord_w-1:0] shot_x;
    logic [coord_w-1:0] shot_y;

    // shot capture side
    modport src (
        output fire,
        output reload,
        output shot_x,
        output shot_y
    );

    // game logic side
    modport dst (
        input fire,
        input reload,
        input shot_x,
        input shot_y
    );

endinterface

// File: logic/shot_capture.sv
`timescale 1ns/1ps

module shot_capture (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              left_mouse,
    input  logic                              right_mouse,
    input  logic [duck_game_pkg::coord_w-1:0] mouse_xpos,
    input  logic [duck_game_pkg::coord_w-1:0] mouse_ypos,
    shot_if.src                               shot
);

    // sampled buttons
    logic left_q;
    logic right_q;
    // buttons one sample earlier
    logic left_prev;
    logic right_prev;
    // rising edge seen between the two samples
    logic left_rise;
    logic right_rise;

    assign left_rise  = left_q & ~left_prev;
    assign right_rise = right_q & ~right_prev;

    // --------------------
    // button sampling and edge pulses
    // --------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            left_q      <= 1'b0;
            right_q     <= 1'b0;
            left_prev   <= 1'b0;
            right_prev  <= 1'b0;
            shot.fire   <= 1'b0;
            shot.reload <= 1'b0;
        end else begin
            left_q      <= left_mouse;
            right_q     <= right_mouse;
            left_prev   <= left_q;
            right_prev  <= right_q;
            // both pulses may fire together
            shot.fire   <= left_rise;
            shot.reload <= right_rise;
        end
    end

    // --------------------
    // position latch
    // --------------------

    // position taken on the edge that raises a pulse, held until the next shot
    always_ff @(posedge clk) begin
        if (left_rise || right_rise) begin
            shot.shot_x <= mouse_xpos;
            shot.shot_y <= mouse_ypos;
        end
    end

endmodule

// File: logic/target_lfsr.sv
`timescale 1ns/1ps

module target_lfsr #(
    parameter logic [15:0] seed = 16'hace1
) (
    input  logic                            clk,
    input  logic                            rst,
    output logic [duck_game_pkg::rnd_w-1:0] rnd
);

    // feedback from taps 16, 14, 13, 11
    logic feedback;

    // maximal-length polynomial, so a nonzero seed never reaches zero
    assign feedback = rnd[15] ^ rnd[13] ^ rnd[12] ^ rnd[10];

    // --------------------
    // shift register
    // --------------------

    // shifts left once per cycle, new bit enters at the bottom
    always_ff @(posedge clk) begin
        if (rst) begin
            rnd <= seed;
        end else begin
            rnd <= {rnd[14:0], feedback};
        end
    end

endmodule

// File: logic/duck_game_logic.sv
`timescale 1ns/1ps

module duck_game_logic (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              game_enable,
    input  logic [duck_game_pkg::rnd_w-1:0]   rnd,
    shot_if.dst                               shot,
    output logic [duck_game_pkg::coord_w-1:0] target_xpos,
    output logic [duck_game_pkg::coord_w-1:0] target_ypos,
    output logic [duck_game_pkg::count_w-1:0] bullets_count,
    output logic                              reload_enable,
    output logic                              hunting,
    output logic [duck_game_pkg::score_w-1:0] score
);
    import duck_game_pkg::*;

    // the hunting port hides the enum literal, so the state is named with its package

    game_state_e        state;
    game_state_e        state_nxt;
    logic [delay_w-1:0] delay_cnt;
    logic [delay_w-1:0] delay_cnt_nxt;
    logic [coord_w-1:0] target_xpos_nxt;
    logic [coord_w-1:0] target_ypos_nxt;
    logic [count_w-1:0] bullets_count_nxt;
    logic [score_w-1:0] score_nxt;
    logic               reload_enable_nxt;
    // new horizontal spawn point, low 10 bits of the random source
    logic [coord_w-1:0] new_xpos;
    logic               in_box;
    logic               hit;

    assign new_xpos = coord_w'(rnd[9:0]);

    // hit box is inclusive on all sides
    assign in_box = (shot.shot_x >= target_xpos) &&
                    (shot.shot_x <= target_xpos + duck_width) &&
                    (shot.shot_y >= target_ypos) &&
                    (shot.shot_y <= target_ypos + duck_height);

    // an empty magazine never scores
    assign hit = shot.fire && (bullets_count != '0) && in_box;

    // --------------------
    // state register
    // --------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= wait_for_start;
        end else begin
            state <= state_nxt;
        end
    end

    // --------------------
    // next state
    // --------------------

    always_comb begin
        case (state)
            wait_for_start: state_nxt = game_enable ? delay : wait_for_start;
            delay:          state_nxt = (delay_cnt == '0) ? duck_game_pkg::hunting : delay;
            duck_game_pkg::hunting: begin
                state_nxt = (shot.fire || shot.reload) ? resolve : duck_game_pkg::hunting;
            end
            resolve:        state_nxt = delay;
            default:        state_nxt = wait_for_start;
        endcase
    end

    // --------------------
    // next outputs, chosen by the next state
    // --------------------

    always_comb begin
        // hold by default
        target_xpos_nxt   = target_xpos;
        target_ypos_nxt   = target_ypos;
        bullets_count_nxt = bullets_count;
        reload_enable_nxt = reload_enable;
        score_nxt         = score;
        delay_cnt_nxt     = delay_cnt;

        case (state_nxt)
            wait_for_start: begin
                // fresh game, target already on the launch line
                target_xpos_nxt   = new_xpos;
                target_ypos_nxt   = coord_w'(lowest_point);
                bullets_count_nxt = count_w'(magazine_size);
                reload_enable_nxt = 1'b0;
                score_nxt         = '0;
                delay_cnt_nxt     = delay_w'(countdown_cycles);
            end
            delay: begin
                // the entry cycle keeps the loaded value
                if (state == delay) begin
                    delay_cnt_nxt = delay_cnt - 1'b1;
                end
            end
            resolve: begin
                // magazine
                if (bullets_count != '0) begin
                    bullets_count_nxt = bullets_count - 1'b1;
                    reload_enable_nxt = 1'b0;
                end else if (shot.reload) begin
                    bullets_count_nxt = count_w'(magazine_size);
                    reload_enable_nxt = 1'b0;
                end else if (shot.fire) begin
                    reload_enable_nxt = 1'b1;
                end

                // hit check, a hit respawns the duck
                if (hit) begin
                    if (score < score_w'(score_max)) begin
                        score_nxt = score + 1'b1;
                    end
                    target_xpos_nxt = new_xpos;
                    target_ypos_nxt = coord_w'(lowest_point);
                    delay_cnt_nxt   = delay_w'(death_cycles);
                end else begin
                    delay_cnt_nxt   = delay_w'(reload_cycles);
                end
            end
            default: begin
                // hunting keeps everything still
            end
        endcase
    end

    // --------------------
    // output registers
    // --------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            target_xpos   <= '0;
            target_ypos   <= '0;
            bullets_count <= '0;
            reload_enable <= 1'b0;
            score         <= '0;
            hunting       <= 1'b0;
            delay_cnt     <= delay_w'(countdown_cycles);
        end else begin
            target_xpos   <= target_xpos_nxt;
            target_ypos   <= target_ypos_nxt;
            bullets_count <= bullets_count_nxt;
            reload_enable <= reload_enable_nxt;
            score         <= score_nxt;
            hunting       <= (state_nxt == duck_game_pkg::hunting);
            delay_cnt     <= delay_cnt_nxt;
        end
    end

endmodule

// File: logic/score_digits.sv
`timescale 1ns/1ps

module score_digits (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [duck_game_pkg::score_w-1:0] score,
    output logic [duck_game_pkg::digit_w-1:0] score_tens,
    output logic [duck_game_pkg::digit_w-1:0] score_ones
);
    import duck_game_pkg::*;

    logic [digit_w-1:0] tens_nxt;
    // tens times ten, taken off the score for the ones digit
    logic [score_w-1:0] base;
    logic [score_w-1:0] rest;

    // --------------------
    // tens ladder
    // --------------------

    // highest step first, score never passes 99
    always_comb begin
        if (score >= 7'd90) begin
            tens_nxt = 4'd9;
            base     = 7'd90;
        end else if (score >= 7'd80) begin
            tens_nxt = 4'd8;
            base     = 7'd80;
        end else if (score >= 7'd70) begin
            tens_nxt = 4'd7;
            base     = 7'd70;
        end else if (score >= 7'd60) begin
            tens_nxt = 4'd6;
            base     = 7'd60;
        end else if (score >= 7'd50) begin
            tens_nxt = 4'd5;
            base     = 7'd50;
        end else if (score >= 7'd40) begin
            tens_nxt = 4'd4;
            base     = 7'd40;
        end else if (score >= 7'd30) begin
            tens_nxt = 4'd3;
            base     = 7'd30;
        end else if (score >= 7'd20) begin
            tens_nxt = 4'd2;
            base     = 7'd20;
        end else if (score >= 7'd10) begin
            tens_nxt = 4'd1;
            base     = 7'd10;
        end else begin
            tens_nxt = 4'd0;
            base     = 7'd0;
        end
    end

    // remainder is always below ten
    assign rest = score - base;

    // one cycle behind the score
    always_ff @(posedge clk) begin
        if (rst) begin
            score_tens <= '0;
            score_ones <= '0;
        end else begin
            score_tens <= tens_nxt;
            score_ones <= rest[digit_w-1:0];
        end
    end

endmodule

// File: logic/duck_game_top.sv
`timescale 1ns/1ps

module duck_game_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              game_enable,
    input  logic                              left_mouse,
    input  logic                              right_mouse,
    input  logic [duck_game_pkg::coord_w-1:0] mouse_xpos,
    input  logic [duck_game_pkg::coord_w-1:0] mouse_ypos,
    output logic [duck_game_pkg::coord_w-1:0] target_xpos,
    output logic [duck_game_pkg::coord_w-1:0] target_ypos,
    output logic [duck_game_pkg::count_w-1:0] bullets_count,
    output logic                              reload_enable,
    output logic                              hunting,
    output logic [duck_game_pkg::digit_w-1:0] score_tens,
    output logic [duck_game_pkg::digit_w-1:0] score_ones
);

    logic [duck_game_pkg::rnd_w-1:0]   rnd;
    logic [duck_game_pkg::score_w-1:0] score;

    // captured shot, input side to game logic
    shot_if i_shot ();

    // --------------------
    // input side
    // --------------------

    shot_capture i_shot_capture (
        .clk         (clk),
        .rst         (rst),
        .left_mouse  (left_mouse),
        .right_mouse (right_mouse),
        .mouse_xpos  (mouse_xpos),
        .mouse_ypos  (mouse_ypos),
        .shot        (i_shot.src)
    );

    target_lfsr i_target_lfsr (
        .clk (clk),
        .rst (rst),
        .rnd (rnd)
    );

    // --------------------
    // game logic and score display
    // --------------------

    duck_game_logic i_duck_game_logic (
        .clk           (clk),
        .rst           (rst),
        .game_enable   (game_enable),
        .rnd           (rnd),
        .shot          (i_shot.dst),
        .target_xpos   (target_xpos),
        .target_ypos   (target_ypos),
        .bullets_count (bullets_count),
        .reload_enable (reload_enable),
        .hunting       (hunting),
        .score         (score)
    );

    score_digits i_score_digits (
        .clk        (clk),
        .rst        (rst),
        .score      (score),
        .score_tens (score_tens),
        .score_ones (score_ones)
    );

endmodule

// File: tests/duck_game_clk.sv
`timescale 1ns/1ps

module duck_game_clk (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held for the first 8 rising edges
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: tests/duck_game_chk.sv
`timescale 1ns/1ps

module duck_game_chk (
    input logic                              clk,
    input logic                              rst,
    input duck_game_pkg::game_state_e        state,
    input logic                              hunting,
    input logic                              fire,
    input logic                              reload,
    input logic [duck_game_pkg::count_w-1:0] bullets_count,
    input logic                              reload_enable,
    input logic [duck_game_pkg::score_w-1:0] score
);
    import duck_game_pkg::*;

    // --------------------
    // magazine
    // --------------------

    // never more rounds than the magazine holds
    bullets_max_a: assert property (@(posedge clk) disable iff (rst)
        bullets_count <= count_w'(magazine_size))
        else $error("bullets_count above magazine size");

    // reload request only with an empty magazine
    reload_empty_a: assert property (@(posedge clk) disable iff (rst)
        reload_enable |-> (bullets_count == '0))
        else $error("reload_enable raised with rounds left");

    // --------------------
    // score and state
    // --------------------

    // one point per hit at most
    score_step_a: assert property (@(posedge clk) disable iff (rst)
        (score == $past(score)) || (score == $past(score) + 1'b1))
        else $error("score jumped by more than one");

    // a shot pulse taken while hunting drops hunting for its resolution
    resolve_idle_a: assert property (@(posedge clk) disable iff (rst)
        (hunting && (fire || reload)) |=> ((state == resolve) && !hunting))
        else $error("hunting high during shot resolution");

endmodule

bind duck_game_logic duck_game_chk i_duck_game_chk (
    .clk           (clk),
    .rst           (rst),
    .state         (state),
    .hunting       (hunting),
    .fire          (shot.fire),
    .reload        (shot.reload),
    .bullets_count (bullets_count),
    .reload_enable (reload_enable),
    .score         (score)
);

// File: tests/duck_game_tb.sv
`timescale 1ns/1ps

module duck_game_tb;
    import duck_game_pkg::*;

    // table fields, {right button, aim on target, offset into the box}
    localparam logic left_btn    = 1'b0;
    localparam logic right_btn   = 1'b1;
    localparam logic off_aim     = 1'b0;
    localparam logic on_aim      = 1'b1;
    localparam int   n_shots     = 22;
    localparam int   cycle_limit = n_shots * (death_cycles + 20) + countdown_cycles + 200;

    logic               clk;
    logic               rst;
    logic               game_enable;
    logic               left_mouse;
    logic               right_mouse;
    logic [coord_w-1:0] mouse_xpos;
    logic [coord_w-1:0] mouse_ypos;
    logic [coord_w-1:0] target_xpos;
    logic [coord_w-1:0] target_ypos;
    logic [count_w-1:0] bullets_count;
    logic               reload_enable;
    logic               hunting;
    logic [digit_w-1:0] score_tens;
    logic [digit_w-1:0] score_ones;

    // --------------------
    // stimulus table
    // --------------------

    logic [8:0] shot_table [0:n_shots-1] = '{
        // first magazine, box corners included
        {left_btn,  on_aim,  7'd0},
        {left_btn,  on_aim,  7'd96},
        {left_btn,  off_aim, 7'd0},
        {left_btn,  on_aim,  7'd48},
        {left_btn,  on_aim,  7'd32},
        {left_btn,  off_aim, 7'd0},
        {left_btn,  on_aim,  7'd10},
        {left_btn,  on_aim,  7'd75},
        // empty magazine, aimed on target anyway
        {left_btn,  on_aim,  7'd20},
        {right_btn, off_aim, 7'd0},
        // second magazine, all hits to pass ten
        {left_btn,  on_aim,  7'd5},
        {left_btn,  on_aim,  7'd60},
        {left_btn,  on_aim,  7'd90},
        {left_btn,  on_aim,  7'd15},
        {left_btn,  on_aim,  7'd33},
        {left_btn,  on_aim,  7'd1},
        {left_btn,  on_aim,  7'd95},
        {left_btn,  on_aim,  7'd64},
        {left_btn,  off_aim, 7'd0},
        {right_btn, on_aim,  7'd0},
        // right button with rounds left still spends one
        {right_btn, off_aim, 7'd0},
        {left_btn,  on_aim,  7'd50}
    };

    // reference model state
    int                 m_bullets = magazine_size;
    logic               m_reload  = 1'b0;
    int                 m_score   = 0;
    // error counters, one per kind of result
    int                 coord_errors = 0;
    int                 count_errors = 0;
    int                 flag_errors  = 0;
    int                 digit_errors = 0;
    int                 cycle_count  = 0;
    int unsigned        seed;
    int                 total;
    logic [8:0]         entry;
    logic [coord_w-1:0] aim_x;
    logic [coord_w-1:0] aim_y;
    logic [coord_w-1:0] old_x;
    logic               shot_hit;

    duck_game_clk i_duck_game_clk (
        .clk (clk),
        .rst (rst)
    );

    duck_game_top i_duck_game_top (
        .clk           (clk),
        .rst           (rst),
        .game_enable   (game_enable),
        .left_mouse    (left_mouse),
        .right_mouse   (right_mouse),
        .mouse_xpos    (mouse_xpos),
        .mouse_ypos    (mouse_ypos),
        .target_xpos   (target_xpos),
        .target_ypos   (target_ypos),
        .bullets_count (bullets_count),
        .reload_enable (reload_enable),
        .hunting       (hunting),
        .score_tens    (score_tens),
        .score_ones    (score_ones)
    );

    // --------------------
    // compare tasks
    // --------------------

    task automatic check_coord(input string name, input logic [coord_w-1:0] exp,
                               input logic [coord_w-1:0] act);
        if (act !== exp) begin
            coord_errors++;
            $display("Error: %s expected 0x%0h, got 0x%0h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input logic [score_w-1:0] exp,
                               input logic [score_w-1:0] act);
        if (act !== exp) begin
            count_errors++;
            $display("Error: %s expected 0x%0h, got 0x%0h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errors++;
            $display("Error: %s expected 0x%0h, got 0x%0h", name, exp, act);
        end
    endtask

    task automatic check_digit(input string name, input logic [digit_w-1:0] exp,
                               input logic [digit_w-1:0] act);
        if (act !== exp) begin
            digit_errors++;
            $display("Error: %s expected 0x%0h, got 0x%0h", name, exp, act);
        end
    endtask

    // --------------------
    // drive helpers and model
    // --------------------

    task automatic drive_buttons(input logic is_right, input logic [coord_w-1:0] x,
                                 input logic [coord_w-1:0] y);
        @(posedge clk);
        mouse_xpos <= x;
        mouse_ypos <= y;
        if (is_right) begin
            right_mouse <= 1'b1;
        end else begin
            left_mouse <= 1'b1;
        end
    endtask

    task automatic release_buttons();
        @(posedge clk);
        left_mouse  <= 1'b0;
        right_mouse <= 1'b0;
    endtask

    // resolution rules applied to one shot
    task automatic resolve_model(input logic is_right, input logic aim_in_box, output logic hit);
        hit = 1'b0;
        if (m_bullets > 0) begin
            hit       = !is_right && aim_in_box;
            m_bullets = m_bullets - 1;
        end else if (is_right) begin
            m_bullets = magazine_size;
            m_reload  = 1'b0;
        end else begin
            m_reload = 1'b1;
        end
        // two digits on the display
        if (hit && m_score < score_max) begin
            m_score++;
        end
    endtask

    // --------------------
    // run limit
    // --------------------

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the game stopped responding after %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        seed = 32'hf46057df;
        void'($urandom(seed));
        game_enable <= 1'b0;
        left_mouse  <= 1'b0;
        right_mouse <= 1'b0;
        mouse_xpos  <= '0;
        mouse_ypos  <= '0;
        @(negedge clk);
        while (rst) @(negedge clk);

        // start the game, then look at the countdown outputs
        @(posedge clk);
        game_enable <= 1'b1;
        repeat (3) @(negedge clk);
        check_coord("target_ypos", coord_w'(lowest_point), target_ypos);
        check_coord("target_xpos above bit 9", '0, target_xpos & 12'hc00);
        check_count("bullets_count", score_w'(magazine_size), score_w'(bullets_count));
        old_x = target_xpos;

        // presses during the countdown, aimed on target, must be ignored
        drive_buttons(left_btn, target_xpos + 12'd10, target_ypos + 12'd5);
        repeat (3) release_buttons();
        drive_buttons(right_btn, target_xpos + 12'd10, target_ypos + 12'd5);
        repeat (3) release_buttons();
        @(negedge clk);
        while (!hunting) @(negedge clk);
        check_coord("target_xpos", old_x, target_xpos);
        check_coord("target_ypos", coord_w'(lowest_point), target_ypos);
        check_count("bullets_count", score_w'(magazine_size), score_w'(bullets_count));
        check_flag("reload_enable", 1'b0, reload_enable);
        check_count("score", '0, i_duck_game_top.score);
        check_digit("score_tens", '0, score_tens);
        check_digit("score_ones", '0, score_ones);

        // --------------------
        // table-driven shots
        // --------------------

        for (int i = 0; i < n_shots; i++) begin
            entry = shot_table[i];
            while (!hunting) @(negedge clk);
            old_x = target_xpos;
            if (entry[7]) begin
                aim_x = target_xpos + coord_w'(entry[6:0]);
                aim_y = target_ypos + coord_w'(entry[6:0] % 7'd33);
            end else begin
                // just right of the box by a random margin
                aim_x = target_xpos + coord_w'(duck_width + 1) + coord_w'($urandom % 200);
                aim_y = target_ypos;
            end
            drive_buttons(entry[8], aim_x, aim_y);

            // press resolves on the third edge, hunting falls with it
            repeat (3) @(negedge clk);
            check_flag("hunting", 1'b1, hunting);
            @(negedge clk);
            check_flag("hunting", 1'b0, hunting);

            // resolved outputs update on the edge that drops hunting
            resolve_model(entry[8], entry[7], shot_hit);
            check_count("bullets_count", score_w'(m_bullets), score_w'(bullets_count));
            check_flag("reload_enable", m_reload, reload_enable);
            check_count("score", score_w'(m_score), i_duck_game_top.score);
            check_coord("target_ypos", coord_w'(lowest_point), target_ypos);
            if (shot_hit) begin
                check_coord("target_xpos above bit 9", '0, target_xpos & 12'hc00);
            end else begin
                check_coord("target_xpos", old_x, target_xpos);
            end

            // digits trail the score by one cycle
            release_buttons();
            @(negedge clk);
            check_digit("score_tens", digit_w'(m_score / 10), score_tens);
            check_digit("score_ones", digit_w'(m_score % 10), score_ones);
        end

        total = coord_errors + count_errors + flag_errors + digit_errors;
        $display("error counts: coord %0d, count %0d, flag %0d, digit %0d",
                 coord_errors, count_errors, flag_errors, digit_errors);
        if (total == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: duck_game.f
logic/duck_game_pkg.sv
logic/shot_if.sv
logic/shot_capture.sv
logic/target_lfsr.sv
logic/duck_game_logic.sv
logic/score_digits.sv
logic/duck_game_top.sv
tests/duck_game_clk.sv
tests/duck_game_chk.sv
tests/duck_game_tb.sv

// File: Bender.yml
package:
  name: duck_game

sources:
  # design, package first
  - files:
      - logic/duck_game_pkg.sv
      - logic/shot_if.sv
      - logic/shot_capture.sv
      - logic/target_lfsr.sv
      - logic/duck_game_logic.sv
      - logic/score_digits.sv
      - logic/duck_game_top.sv

  # testbench, checker and clock
  - target: test
    files:
      - tests/duck_game_clk.sv
      - tests/duck_game_chk.sv
      - tests/duck_game_tb.sv
